//--- testbench/ramio_cases.txt
# op addr type data expected, all hex after op
# W store, R load and wait, Q load without waiting, P poll until expected, L check led
R fffffffc 3 00000000 0000000f
L 00000000 0 00000000 0000000f
R fffffff8 3 00000000 ffffffff
R fffffff4 3 00000000 ffffffff
W 00000000 3 11223344 00000000
W 00000004 3 deadbeef 00000000
W 00000ffc 3 a5a5c3c3 00000000
R 00000000 3 00000000 11223344
R 00000004 7 00000000 deadbeef
R 00000ffc 3 00000000 a5a5c3c3
R 00001004 3 00000000 deadbeef
R 00000007 3 00000000 deadbeef
W 00000010 3 8899aabb 00000000
W 00000011 1 0000007f 00000000
W 00000013 1 00000080 00000000
W 00000010 2 0000fe01 00000000
W 00000011 2 00001234 00000000
R 00000010 3 00000000 8099fe01
R 00000010 1 00000000 00000001
R 00000011 5 00000000 fffffffe
R 00000011 1 00000000 000000fe
R 00000013 1 00000000 00000080
R 00000013 5 00000000 ffffff80
R 00000010 6 00000000 fffffe01
R 00000012 2 00000000 00008099
R 00000012 6 00000000 ffff8099
R 00000011 2 00000000 00000000
R 00000013 6 00000000 00000000
W 00000020 3 00000000 00000000
W 00000020 1 000000a1 00000000
W 00000022 2 0000c3d4 00000000
W 00000022 1 ffffffb2 00000000
R 00000020 3 00000000 c3b200a1
R 00000022 2 00000000 0000c3b2
R 00000020 5 00000000 ffffffa1
Q 00000000 3 00000000 11223344
Q 00000012 5 00000000 ffffff99
Q 00000004 3 00000000 deadbeef
R 00000ffc 3 00000000 a5a5c3c3
W fffffffc 3 000000f5 00000000
L 00000000 0 00000000 00000005
R fffffffc 3 00000000 00000005
W fffffff8 1 00000055 00000000
R fffffff8 3 00000000 00000055
P fffffff8 3 00000000 ffffffff
P fffffff4 3 00000000 00000055
R fffffff4 3 00000000 ffffffff

//--- ramio.f
+incdir+hdl
hdl/ramio_pkg.sv
hdl/ramio_lane.sv
hdl/word_ram.sv
hdl/io_regs.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/ramio.sv
testbench/ramio_sva.sv
testbench/ramio_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the ramio testbench with Verilator and run it from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f ramio.f --top-module ramio_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

# keep going after an assertion error so the testbench prints its verdict
out=$(./obj_dir/Vramio_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
exit 1

//--- testbench/ramio_tb.sv
// --------------------------------------------------------------------------
// testbench for the load/store port with cases from ramio_cases.txt
// run from the project root
// uart_tx loops straight back to uart_rx
// polls leave an idle cycle between reads so UART in can latch a byte
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "ramio_consts.svh"

module ramio_tb;
  import ramio_pkg::*;

  localparam int max_cases    = 96;
  localparam int reset_cycles = 8;
  // cycle budget of one case and the poll limit
  localparam int case_cycles  = 12 * `RAMIO_CLKS_PER_BIT + 20;

  logic       clk;
  logic       rst_n;
  logic       enable;
  mem_req_t   req;
  word_t      data_out;
  logic       data_out_ready;
  logic [3:0] led;
  logic       uart_line;

  // ------------------------------------------------------------------------
  // case table and loads in flight
  // ------------------------------------------------------------------------
  logic [7:0] c_op   [max_cases];
  word_t      c_addr [max_cases];
  logic [2:0] c_type [max_cases];
  word_t      c_data [max_cases];
  word_t      c_exp  [max_cases];
  int         n_cases;
  bit         cases_loaded;
  word_t      exp_q[$];
  int         idx_q[$];
  // set while polling so the result goes to captured instead of the queue
  bit         capture;
  word_t      captured;
  bit         captured_valid;
  int         pass_count;
  int         fail_count;

  ramio dut0 (
    .clk, .rst_n, .enable, .req, .data_out, .data_out_ready, .led,
    .uart_tx(uart_line), .uart_rx(uart_line)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic check_word(input string name, input word_t got, input word_t exp,
                            output bit ok);
    ok = (got === exp);
    if (!ok) begin
      $display("[ERROR] %s got %08h expected %08h", name, got, exp);
    end
  endtask

  task automatic check_led(input string name, input logic [3:0] got,
                           input logic [3:0] exp, output bit ok);
    ok = (got === exp);
    if (!ok) begin
      $display("[ERROR] %s got %01h expected %01h", name, got, exp);
    end
  endtask

  task automatic report_case(input int idx, input bit ok);
    if (ok) begin
      pass_count++;
    end else begin
      fail_count++;
    end
    $display("case %0d %c %08h %s", idx, c_op[idx], c_addr[idx], ok ? "ok" : "failed");
  endtask

  function automatic mem_req_t make_req(input word_t addr, input word_t data,
                                        input logic [2:0] rtype, input logic [1:0] wtype);
    mem_req_t r;
    r.address    = addr;
    r.wdata      = data;
    r.read_type  = read_type_e'(rtype);
    r.write_type = write_type_e'(wtype);
    return r;
  endfunction

  task automatic load_cases();
    int         fd;
    int         n;
    string      line;
    logic [7:0] op;
    logic [2:0] t;
    word_t      a;
    word_t      d;
    word_t      e;
    n  = 0;
    fd = $fopen("testbench/ramio_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/ramio_cases.txt");
    end else begin
      while (!$feof(fd) && n < max_cases) begin
        line = "";
        void'($fgets(line, fd));
        // skip blank and comment lines
        if (line.len() > 1 && line[0] != "#") begin
          if ($sscanf(line, "%c %h %h %h %h", op, a, t, d, e) == 5) begin
            c_op[n]   = op;
            c_addr[n] = a;
            c_type[n] = t;
            c_data[n] = d;
            c_exp[n]  = e;
            n++;
          end else begin
            $display("malformed line in case file: %s", line);
            fail_count++;
          end
        end
      end
      $fclose(fd);
    end
    n_cases      = n;
    cases_loaded = 1'b1;
  endtask

  // ------------------------------------------------------------------------
  // one clock of stimulus with results sampled at the falling edge
  // ------------------------------------------------------------------------
  task automatic collect_result();
    word_t exp;
    int    idx;
    bit    ok;
    if (data_out_ready) begin
      if (capture) begin
        captured       = data_out;
        captured_valid = 1'b1;
      end else if (exp_q.size() == 0) begin
        $display("data_out_ready went high with no load outstanding");
        fail_count++;
      end else begin
        exp = exp_q.pop_front();
        idx = idx_q.pop_front();
        check_word("data_out", data_out, exp, ok);
        report_case(idx, ok);
      end
    end
  endtask

  task automatic drive_cycle(input logic en, input mem_req_t r);
    @(posedge clk);
    enable <= en;
    req    <= r;
    @(negedge clk);
    collect_result();
  endtask

  // idle until every queued load has returned
  task automatic drain_loads();
    int    guard;
    int    idx;
    word_t exp;
    guard = 0;
    while (exp_q.size() != 0 && guard < 4) begin
      drive_cycle(1'b0, '0);
      guard++;
    end
    while (exp_q.size() != 0) begin
      idx = idx_q.pop_front();
      exp = exp_q.pop_front();
      $display("case %0d load of %08h never saw data_out_ready", idx, exp);
      report_case(idx, 1'b0);
    end
  endtask

  task automatic run_load(input int idx, input bit wait_done);
    exp_q.push_back(c_exp[idx]);
    idx_q.push_back(idx);
    drive_cycle(1'b1, make_req(c_addr[idx], '0, c_type[idx], 2'b00));
    if (wait_done) begin
      drain_loads();
    end
  endtask

  task automatic run_store(input int idx);
    drive_cycle(1'b1, make_req(c_addr[idx], c_data[idx], 3'b000, c_type[idx][1:0]));
    report_case(idx, 1'b1);
  endtask

  task automatic run_led(input int idx);
    bit ok;
    // led updates on the edge after the store
    drive_cycle(1'b0, '0);
    check_led("led", led, c_exp[idx][3:0], ok);
    report_case(idx, ok);
  endtask

  task automatic run_poll(input int idx);
    int tries;
    bit hit;
    tries   = 0;
    hit     = 1'b0;
    capture = 1'b1;
    while (!hit && tries < case_cycles / 2) begin
      captured_valid = 1'b0;
      drive_cycle(1'b1, make_req(c_addr[idx], '0, c_type[idx], 2'b00));
      drive_cycle(1'b0, '0);
      hit = captured_valid && captured === c_exp[idx];
      tries++;
    end
    capture = 1'b0;
    if (!hit) begin
      $display("case %0d poll of %08h never returned %08h", idx, c_addr[idx], c_exp[idx]);
    end
    report_case(idx, hit);
  endtask

  // ------------------------------------------------------------------------
  // main sequence and watchdog
  // ------------------------------------------------------------------------
  initial begin
    rst_n          = 1'b0;
    enable         = 1'b0;
    req            = '0;
    capture        = 1'b0;
    captured       = '0;
    captured_valid = 1'b0;
    pass_count     = 0;
    fail_count     = 0;
    n_cases        = 0;
    cases_loaded   = 1'b0;
    load_cases();
    if (n_cases == 0) begin
      $display("no cases to run");
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < n_cases; i++) begin
        case (c_op[i])
          "W": run_store(i);
          "R": run_load(i, 1'b1);
          "Q": run_load(i, 1'b0);
          "P": run_poll(i);
          "L": run_led(i);
          default: begin
            $display("case %0d has unknown op %c", i, c_op[i]);
            fail_count++;
          end
        endcase
      end
      drain_loads();
      repeat (2) drive_cycle(1'b0, '0);
      $display("%0d passed, %0d failed, %0d assertion failures",
               pass_count, fail_count, dut0.sva0.assert_fails);
      if (fail_count == 0 && dut0.sva0.assert_fails == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

  initial begin
    wait (cases_loaded);
    repeat (reset_cycles + n_cases * case_cycles) @(posedge clk);
    $display("watchdog expired before all cases finished");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- testbench/ramio_sva.sv
// --------------------------------------------------------------------------
// timing assertions for the load/store port, bound into every ramio
// checked only while out of reset
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module ramio_sva (
  input logic                clk,
  input logic                rst_n,
  input logic                enable,
  input ramio_pkg::mem_req_t req,
  input ramio_pkg::io_sel_e  sel,
  input logic                data_out_ready,
  input logic                io_rd,
  input logic                uart_tx,
  input logic                tx_busy
);
  import ramio_pkg::*;

  // failures seen so far, read by the testbench at the end
  int   assert_fails = 0;
  logic ram_load;

  assign ram_load = enable && sel == sel_ram && req.read_type != rd_none;

  // RAM load result comes exactly one cycle later
  a_load_ready: assert property (@(posedge clk) disable iff (!rst_n)
    ram_load |=> data_out_ready)
    else begin
      $error("data_out_ready missing one cycle after a RAM load");
      assert_fails++;
    end

  // ready only for an I/O load now or a RAM load one cycle back, never a store
  a_ready_source: assert property (@(posedge clk) disable iff (!rst_n)
    data_out_ready |-> io_rd || $past(ram_load))
    else begin
      $error("data_out_ready without a load behind it");
      assert_fails++;
    end

  // idle line stays high
  a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !tx_busy |-> uart_tx)
    else begin
      $error("uart_tx low while transmitter idle");
      assert_fails++;
    end

endmodule

bind ramio ramio_sva sva0 (
  .clk, .rst_n, .enable, .req, .sel, .data_out_ready, .io_rd, .uart_tx, .tx_busy
);

//--- hdl/ramio.sv
// --------------------------------------------------------------------------
// load/store port for RAM and memory-mapped I/O
// I/O loads are ready in the enable cycle, RAM loads one cycle later
// an I/O load in the cycle a RAM result returns takes data_out
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "ramio_consts.svh"

module ramio (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                enable,
  input  ramio_pkg::mem_req_t req,
  output ramio_pkg::word_t    data_out,
  output logic                data_out_ready,
  output logic [3:0]          led,
  output logic                uart_tx,
  input  logic                uart_rx
);
  import ramio_pkg::*;

  io_sel_e    sel;
  logic       lane_valid;
  logic       io_wr;
  logic       io_rd;
  ram_cmd_t   ram_cmd;
  word_t      ram_rdata;
  word_t      lane_data;
  logic       lane_ready;
  word_t      io_rdata;
  logic       tx_go;
  logic [7:0] tx_byte;
  logic       tx_busy;
  logic       rx_go;
  logic [7:0] rx_byte;
  logic       rx_ready;

  // full-address match for the I/O words
  always_comb begin
    case (req.address)
      `RAMIO_ADDR_LED:      sel = sel_led;
      `RAMIO_ADDR_UART_OUT: sel = sel_uart_out;
      `RAMIO_ADDR_UART_IN:  sel = sel_uart_in;
      default:              sel = sel_ram;
    endcase
  end

  // each strobe goes to one block only
  assign lane_valid = enable && sel == sel_ram;
  assign io_wr      = enable && sel != sel_ram && req.write_type != wr_none;
  assign io_rd      = enable && sel != sel_ram && req.read_type != rd_none;

  assign data_out       = io_rd ? io_rdata : (lane_ready ? lane_data : '0);
  assign data_out_ready = io_rd || lane_ready;

  ramio_lane lane0 (
    .clk, .rst_n, .req_valid(lane_valid), .req, .ram_cmd,
    .ram_rdata, .rd_data(lane_data), .rd_ready(lane_ready)
  );

  word_ram ram0 (.clk, .cmd(ram_cmd), .rdata(ram_rdata));

  io_regs regs0 (
    .clk, .rst_n, .sel, .wr(io_wr), .rd(io_rd), .wdata(req.wdata), .rdata(io_rdata),
    .led, .tx_go, .tx_byte, .tx_busy, .rx_go, .rx_byte, .rx_ready
  );

  uart_tx #(.ClksPerBit(`RAMIO_CLKS_PER_BIT)) tx0 (
    .clk, .rst_n, .data(tx_byte), .go(tx_go), .busy(tx_busy), .tx(uart_tx)
  );

  uart_rx #(.ClksPerBit(`RAMIO_CLKS_PER_BIT)) rx0 (
    .clk, .rst_n, .rx(uart_rx), .go(rx_go), .data(rx_byte), .data_ready(rx_ready)
  );

endmodule

//--- hdl/uart_rx.sv
// --------------------------------------------------------------------------
// 8N1 deserializer with mid-bit sampling
// data_ready holds until go drops, receiving only starts while go is high
// no framing check on the stop bit
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "ramio_consts.svh"

module uart_rx #(
  parameter int unsigned ClksPerBit = `RAMIO_CLKS_PER_BIT
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       go,
  output logic [7:0] data,
  output logic       data_ready
);
  localparam int cnt_w = $clog2(ClksPerBit);
  localparam logic [cnt_w-1:0] bit_last  = cnt_w'(ClksPerBit - 1);
  localparam logic [cnt_w-1:0] half_last = cnt_w'(ClksPerBit / 2 - 1);

  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_e;

  state_e           state;
  logic [cnt_w-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shreg;
  // two-flop synchronizer
  logic             rx_meta;
  logic             rx_sync;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= st_idle;
      cnt        <= '0;
      bit_idx    <= '0;
      data_ready <= 1'b0;
    end else begin
      // acknowledge from the reader
      if (!go) begin
        data_ready <= 1'b0;
      end
      case (state)
        st_idle: begin
          if (go && !rx_sync) begin
            cnt   <= '0;
            state <= st_start;
          end
        end
        st_start: begin
          // middle of start bit, glitch goes back to idle
          if (cnt == half_last) begin
            cnt <= '0;
            if (!rx_sync) begin
              bit_idx <= '0;
              state   <= st_data;
            end else begin
              state <= st_idle;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_data: begin
          if (cnt == bit_last) begin
            cnt   <= '0;
            shreg <= {rx_sync, shreg[7:1]};
            if (bit_idx == 3'd7) begin
              state <= st_stop;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          // middle of stop bit
          if (cnt == bit_last) begin
            cnt        <= '0;
            data       <= shreg;
            data_ready <= 1'b1;
            state      <= st_idle;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

//--- hdl/uart_tx.sv
// --------------------------------------------------------------------------
// 8N1 serializer, starts when go is high and waits for go low after a byte
// ClksPerBit must be at least 2
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "ramio_consts.svh"

module uart_tx #(
  parameter int unsigned ClksPerBit = `RAMIO_CLKS_PER_BIT
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] data,
  input  logic       go,
  output logic       busy,
  output logic       tx
);
  localparam int cnt_w = $clog2(ClksPerBit);
  localparam logic [cnt_w-1:0] bit_last = cnt_w'(ClksPerBit - 1);

  typedef enum logic [2:0] {st_idle, st_start, st_data, st_stop, st_done} state_e;

  state_e           state;
  logic [cnt_w-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shreg;

  // line and busy follow the state
  assign busy = state inside {st_start, st_data, st_stop};

  always_comb begin
    case (state)
      st_start: tx = 1'b0;
      st_data:  tx = shreg[0];
      default:  tx = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= st_idle;
      cnt     <= '0;
      bit_idx <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (go) begin
            shreg <= data;
            cnt   <= '0;
            state <= st_start;
          end
        end
        st_start: begin
          if (cnt == bit_last) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= st_data;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_data: begin
          // LSB first
          if (cnt == bit_last) begin
            cnt   <= '0;
            shreg <= shreg >> 1;
            if (bit_idx == 3'd7) begin
              state <= st_stop;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_stop: begin
          if (cnt == bit_last) begin
            cnt   <= '0;
            state <= st_done;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        // hold until the sender drops go
        default: begin
          if (!go) begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

endmodule

//--- hdl/io_regs.sv
// --------------------------------------------------------------------------
// LED, UART out and UART in words
// a second UART out write while sending only replaces the register value
// an unread received byte is overwritten by the next one
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module io_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  ramio_pkg::io_sel_e  sel,
  input  logic                wr,
  input  logic                rd,
  input  ramio_pkg::word_t    wdata,
  output ramio_pkg::word_t    rdata,
  output logic [3:0]          led,
  output logic                tx_go,
  output logic [7:0]          tx_byte,
  input  logic                tx_busy,
  output logic                rx_go,
  input  logic [7:0]          rx_byte,
  input  logic                rx_ready
);
  import ramio_pkg::*;

  // byte being sent, all ones when idle
  word_t tx_data;
  // byte received, all ones when none waiting
  word_t rx_data;
  // set the cycle after go rises, busy is not valid yet
  logic  tx_guard;

  assign tx_byte = tx_data[7:0];

  // loads are combinational
  always_comb begin
    case (sel)
      sel_led:      rdata = {28'b0, led};
      sel_uart_out: rdata = tx_data;
      sel_uart_in:  rdata = rx_data;
      default:      rdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // all LEDs off
      led      <= 4'b1111;
      tx_data  <= '1;
      tx_go    <= 1'b0;
      tx_guard <= 1'b0;
      rx_data  <= '1;
      rx_go    <= 1'b1;
    end else begin
      tx_guard <= 1'b0;

      // a read empties UART in and wins over an arriving byte
      // the byte is picked up on a later cycle since rx_go stays high
      if (rd && sel == sel_uart_in) begin
        rx_data <= '1;
      end else if (rx_go && rx_ready) begin
        rx_data <= {24'b0, rx_byte};
        // acknowledge
        rx_go   <= 1'b0;
      end

      // re-arm receiver one cycle after the acknowledge
      if (!rx_go) begin
        rx_go <= 1'b1;
      end

      // transmitter finished
      if (tx_go && !tx_busy && !tx_guard) begin
        tx_go   <= 1'b0;
        tx_data <= '1;
      end

      // a new byte to send overrides the finish above
      if (wr && sel == sel_uart_out) begin
        tx_data  <= {24'b0, wdata[7:0]};
        tx_go    <= 1'b1;
        tx_guard <= 1'b1;
      end

      if (wr && sel == sel_led) begin
        led <= wdata[3:0];
      end
    end
  end

endmodule

//--- hdl/word_ram.sv
// --------------------------------------------------------------------------
// single-port word RAM, per-byte write, read data one cycle after en
// contents are undefined after power up
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "ramio_consts.svh"

module word_ram (
  input  logic               clk,
  input  ramio_pkg::ram_cmd_t cmd,
  output ramio_pkg::word_t    rdata
);
  import ramio_pkg::*;

  localparam int depth = 2 ** `RAMIO_RAM_AW;

  word_t mem [depth];

  // write the enabled bytes
  always_ff @(posedge clk) begin
    if (cmd.en) begin
      for (int i = 0; i < 4; i++) begin
        if (cmd.byte_we[i]) begin
          mem[cmd.word_addr][8*i +: 8] <= cmd.wdata[8*i +: 8];
        end
      end
    end
  end

  // registered read, old data on a same-cycle write
  always_ff @(posedge clk) begin
    if (cmd.en) begin
      rdata <= mem[cmd.word_addr];
    end
  end

endmodule

//--- hdl/ramio_lane.sv
// --------------------------------------------------------------------------
// byte lane handling between client and word RAM
// misaligned half-word stores are dropped and such loads return zero
// word accesses ignore address bits 1:0
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "ramio_consts.svh"

module ramio_lane (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid,
  input  ramio_pkg::mem_req_t req,
  output ramio_pkg::ram_cmd_t ram_cmd,
  input  ramio_pkg::word_t    ram_rdata,
  output ramio_pkg::word_t    rd_data,
  output logic               rd_ready
);
  import ramio_pkg::*;

  logic [1:0] off;
  // lane offset and load kind of the read in flight
  logic [1:0] off_q;
  logic [2:0] rtype_q;
  word_t      lane_word;

  assign off = req.address[1:0];

  // ------------------------------------------------------------------------
  // store side
  // ------------------------------------------------------------------------
  always_comb begin
    ram_cmd.en        = req_valid && (req.read_type != rd_none || req.write_type != wr_none);
    ram_cmd.word_addr = req.address[`RAMIO_RAM_AW+1:2];
    ram_cmd.byte_we   = 4'b0000;
    ram_cmd.wdata     = '0;
    if (req_valid) begin
      case (req.write_type)
        wr_byte: begin
          ram_cmd.byte_we = 4'b0001 << off;
          ram_cmd.wdata   = {24'b0, req.wdata[7:0]} << {off, 3'b000};
        end
        wr_half: begin
          // only offsets 0 and 2 are legal
          if (!off[0]) begin
            ram_cmd.byte_we = 4'b0011 << off;
            ram_cmd.wdata   = {16'b0, req.wdata[15:0]} << {off, 3'b000};
          end
        end
        wr_word: begin
          ram_cmd.byte_we = 4'b1111;
          ram_cmd.wdata   = req.wdata;
        end
        default: ;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // load side
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ready <= 1'b0;
    end else begin
      rd_ready <= req_valid && req.read_type != rd_none;
    end
  end

  // lane info rides along with the RAM read
  always_ff @(posedge clk) begin
    off_q   <= off;
    rtype_q <= req.read_type;
  end

  // addressed byte or half word moved down to bit 0
  assign lane_word = ram_rdata >> {off_q, 3'b000};

  always_comb begin
    rd_data = '0;
    case (rtype_q[1:0])
      2'b01: begin
        rd_data = rtype_q[2] ? {{24{lane_word[7]}}, lane_word[7:0]}
                             : {24'b0, lane_word[7:0]};
      end
      2'b10: begin
        if (!off_q[0]) begin
          rd_data = rtype_q[2] ? {{16{lane_word[15]}}, lane_word[15:0]}
                               : {16'b0, lane_word[15:0]};
        end
      end
      2'b11: rd_data = ram_rdata;
      default: ;
    endcase
  end

endmodule

//--- hdl/ramio_pkg.sv
// --------------------------------------------------------------------------
// access kinds and request structs shared by the port blocks
// --------------------------------------------------------------------------
`include "ramio_consts.svh"

package ramio_pkg;

  typedef logic [31:0] word_t;

  // bit 2 asks for sign extension, bits 1:0 give the size
  typedef enum logic [2:0] {
    rd_none  = 3'b000,
    rd_ubyte = 3'b001,
    rd_uhalf = 3'b010,
    rd_uword = 3'b011,
    rd_sbyte = 3'b101,
    rd_shalf = 3'b110,
    rd_sword = 3'b111
  } read_type_e;

  typedef enum logic [1:0] {
    wr_none = 2'b00,
    wr_byte = 2'b01,
    wr_half = 2'b10,
    wr_word = 2'b11
  } write_type_e;

  // client request, 69 bits
  typedef struct packed {
    word_t       address;
    word_t       wdata;
    read_type_e  read_type;
    write_type_e write_type;
  } mem_req_t;

  // one access into the word RAM
  typedef struct packed {
    logic                     en;
    logic [3:0]               byte_we;
    logic [`RAMIO_RAM_AW-1:0] word_addr;
    word_t                    wdata;
  } ram_cmd_t;

  typedef enum logic [1:0] {
    sel_ram,
    sel_led,
    sel_uart_out,
    sel_uart_in
  } io_sel_e;

endpackage

//--- hdl/ramio_consts.svh
// --------------------------------------------------------------------------
// address map and sizes for the load/store port
// I/O words sit at the top of the address space and match whole addresses
// RAM words alias above address bit RAMIO_RAM_AW+1
// --------------------------------------------------------------------------
`ifndef RAMIO_CONSTS_SVH
`define RAMIO_CONSTS_SVH

// four LEDs in the low nibble, 0 turns a LED on
`define RAMIO_ADDR_LED 32'hffff_fffc

// reads the byte being sent, all ones when idle
`define RAMIO_ADDR_UART_OUT 32'hffff_fff8

// reads the last received byte, all ones when empty
`define RAMIO_ADDR_UART_IN 32'hffff_fff4

// log2 of the RAM depth in 32-bit words
`define RAMIO_RAM_AW 10

// clocks per UART bit
// kept short so simulation runs fast
`define RAMIO_CLKS_PER_BIT 8

`endif
